// ==== files.f ====
monitor_pkg.sv
drp_poll_sequencer.sv
seu_event_counter.sv
sensor_regfile.sv
apb_status_slave.sv
sys_monitor.sv
tb_sys_monitor.sv

// ==== tb_sys_monitor.sv ====
`timescale 1ns/1ps

module tb_sys_monitor;
    import monitor_pkg::*;

    typedef enum int {act_read, act_write, act_status, act_idle, act_poll} action_t;

    typedef struct {
        action_t   action;
        apb_addr_t addr;
        apb_data_t data;      // Write data, status bits or idle cycles
        apb_data_t exp_data;
        logic      exp_err;
    } step_t;

    localparam int interval = 64;

    logic        clk66m;
    logic        rst_66m;
    logic        den;
    drp_addr_t   daddr;
    drp_rsp_t    drp_rsp;
    seu_status_t seu_status;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;

    drp_data_t   drp_mem [128];                  // Sensor block register contents
    drp_addr_t   chan_addr [7] = '{7'h00, 7'h01, 7'h02, 7'h06, 7'h03, 7'h04, 7'h05};
    drp_addr_t   addr_log [$];
    drp_addr_t   pend_addr;
    int          rsp_wait  = 0;
    int          rsp_count = 0;
    step_t       steps [$];

    sys_monitor #(
        .poll_interval (interval)
    ) uut (
        .clk66m     (clk66m),
        .rst_66m    (rst_66m),
        .den        (den),
        .daddr      (daddr),
        .drp_rsp    (drp_rsp),
        .seu_status (seu_status),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp)
    );

    always #50 clk66m = ~clk66m;

    // **************************************************
    // DRP responder with drdy three cycles after den
    // **************************************************
    always @(negedge clk66m) begin
        if (!rst_66m && den) begin
            pend_addr = daddr;
            addr_log.push_back(daddr);
            rsp_wait  = 3;
        end
    end

    always @(posedge clk66m) begin
        #1;
        drp_rsp = '0;
        if (rsp_wait == 1) begin
            drp_rsp.drdy  = 1'b1;
            drp_rsp.rdata = drp_mem[pend_addr];
            rsp_count++;
        end
        if (rsp_wait > 0) begin
            rsp_wait--;
        end
    end

    task automatic tick();
        @(posedge clk66m);
        #1;
    endtask

    task automatic check(string name, apb_data_t actual, apb_data_t expected);
        if (actual !== expected) begin
            $display("ERR %s actual=0x%08h expected=0x%08h", name, actual, expected);
            $display("Regression failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic timeout_fail(string what);
        $display("Timeout while waiting for %s", what);
        $display("Regression failed");
        $fatal(1, "Stopped on timeout");
    endtask

    // Setup phase, then access phase sampled at the falling edge
    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        int waits;
        waits   = 0;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        tick();
        apb_req.penable = 1'b1;
        @(negedge clk66m);
        while (!apb_rsp.pready) begin
            waits++;
            if (waits > 16) begin
                timeout_fail("APB pready");
            end
            @(negedge clk66m);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        tick();
        apb_req = '0;
    endtask

    task automatic wait_for_polls();
        int cycles;
        cycles = 0;
        while (rsp_count < 7) begin
            tick();
            cycles++;
            if (cycles > 10 * interval) begin
                timeout_fail("seven DRP sensor replies");
            end
        end
        repeat (2) tick();                           // drdy to readable register
        foreach (addr_log[i]) begin
            check($sformatf("daddr[%0d]", i), apb_data_t'(addr_log[i]),
                  apb_data_t'(chan_addr[i % 7]));
        end
    endtask

    function automatic void add_step(action_t action, apb_addr_t addr, apb_data_t data,
                                     apb_data_t exp_data, logic exp_err);
        steps.push_back('{action, addr, data, exp_data, exp_err});
    endfunction

    // One status pulse, then back to observation only
    function automatic void add_pulse(apb_data_t bits, apb_data_t high_cycles);
        add_step(act_status, 8'h00, bits, 32'h0, 1'b0);
        add_step(act_idle, 8'h00, high_cycles, 32'h0, 1'b0);
        add_step(act_status, 8'h00, 32'h1, 32'h0, 1'b0);
        add_step(act_idle, 8'h00, 32'd4, 32'h0, 1'b0);
    endfunction

    function automatic void build_table();
        for (int c = 0; c < 7; c++) begin
            add_step(act_read, apb_addr_t'(4 * c), 32'h0, 32'h0, 1'b0);  // Reset values
        end
        add_step(act_read, 8'h1C, 32'h0, 32'h0, 1'b0);
        add_step(act_read, 8'h20, 32'h0, 32'h0, 1'b0);
        add_step(act_read, 8'h24, 32'h0, 32'h1, 1'b0);
        add_step(act_poll, 8'h00, 32'h0, 32'h0, 1'b0);
        for (int c = 0; c < 7; c++) begin
            add_step(act_read, apb_addr_t'(4 * c), 32'h0,
                     apb_data_t'(drp_mem[chan_addr[c]][15:4]), 1'b0);
        end
        // **************************************************
        // Soft-error events
        // **************************************************
        add_pulse(32'h3, 32'd4);
        add_pulse(32'h3, 32'd20);                    // Held level counts once
        add_pulse(32'h3, 32'd4);
        add_step(act_read, 8'h1C, 32'h0, 32'h3, 1'b0);
        add_step(act_read, 8'h20, 32'h0, 32'h0, 1'b0);
        add_step(act_status, 8'h00, 32'h5, 32'h0, 1'b0);
        add_step(act_read, 8'h24, 32'h0, 32'h5, 1'b0);  // Live status while high
        add_step(act_status, 8'h00, 32'h1, 32'h0, 1'b0);
        add_step(act_idle, 8'h00, 32'd4, 32'h0, 1'b0);
        add_pulse(32'h5, 32'd4);
        add_step(act_read, 8'h20, 32'h0, 32'h2, 1'b0);
        add_step(act_read, 8'h1C, 32'h0, 32'h3, 1'b0);
        // Clear, then bad accesses
        add_step(act_write, 8'h28, 32'h1, 32'h0, 1'b0);
        add_step(act_read, 8'h1C, 32'h0, 32'h0, 1'b0);
        add_step(act_read, 8'h20, 32'h0, 32'h0, 1'b0);
        add_step(act_read, 8'h30, 32'h0, 32'h0, 1'b1);
        add_step(act_write, 8'h00, 32'hFFF, 32'h0, 1'b1);
        add_step(act_read, 8'h00, 32'h0, apb_data_t'(drp_mem[chan_addr[0]][15:4]), 1'b0);
    endfunction

    initial begin
        apb_data_t rdata;
        logic      err;
        clk66m     = 1'b0;
        rst_66m    = 1'b1;
        drp_rsp    = '0;
        seu_status = 3'b001;                         // Observation only
        apb_req    = '0;
        void'($urandom(8435));
        for (int a = 0; a < 128; a++) begin
            drp_mem[a] = drp_data_t'($urandom());
        end
        build_table();
        repeat (16) @(posedge clk66m);
        #1;
        rst_66m = 1'b0;
        foreach (steps[i]) begin
            case (steps[i].action)
                act_read, act_write: begin
                    apb_access(steps[i].action == act_write, steps[i].addr, steps[i].data,
                               rdata, err);
                    check($sformatf("prdata at 0x%02h", steps[i].addr), rdata, steps[i].exp_data);
                    check($sformatf("pslverr at 0x%02h", steps[i].addr), apb_data_t'(err),
                          apb_data_t'(steps[i].exp_err));
                end
                act_status: begin
                    seu_status = seu_status_t'(steps[i].data[2:0]);
                    tick();
                end
                act_idle: repeat (steps[i].data) tick();
                act_poll: wait_for_polls();
            endcase
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== sys_monitor.sv ====
`timescale 1ns/1ps

module sys_monitor #(
    parameter int poll_interval = 65536    // Cycles per channel
) (
    input  logic                     clk66m,
    input  logic                     rst_66m,
    // Sensor block DRP
    output logic                     den,
    output monitor_pkg::drp_addr_t   daddr,
    input  monitor_pkg::drp_rsp_t    drp_rsp,
    // Soft-error controller status
    input  monitor_pkg::seu_status_t seu_status,
    // Register bus
    input  monitor_pkg::apb_req_t    apb_req,
    output monitor_pkg::apb_rsp_t    apb_rsp
);
    import monitor_pkg::*;

    sensor_sample_t sample;
    sensor_code_t   codes [num_channels];
    event_count_t   correction_count;
    event_count_t   uncorrectable_count;
    seu_status_t    live_status;
    logic           count_clear;

    // **************************************************
    // Input side
    // **************************************************
    drp_poll_sequencer #(
        .poll_interval (poll_interval)
    ) u_drp_poll_sequencer (
        .clk66m  (clk66m),
        .rst_66m (rst_66m),
        .drp_rsp (drp_rsp),
        .den     (den),
        .daddr   (daddr),
        .sample  (sample)
    );

    seu_event_counter u_seu_event_counter (
        .clk66m              (clk66m),
        .rst_66m             (rst_66m),
        .seu_status          (seu_status),
        .count_clear         (count_clear),
        .correction_count    (correction_count),
        .uncorrectable_count (uncorrectable_count),
        .live_status         (live_status)
    );

    sensor_regfile u_sensor_regfile (
        .clk66m  (clk66m),
        .rst_66m (rst_66m),
        .sample  (sample),
        .codes   (codes)
    );

    // Register side
    apb_status_slave u_apb_status_slave (
        .apb_req             (apb_req),
        .apb_rsp             (apb_rsp),
        .codes               (codes),
        .correction_count    (correction_count),
        .uncorrectable_count (uncorrectable_count),
        .live_status         (live_status),
        .count_clear         (count_clear)
    );

endmodule

// ==== apb_status_slave.sv ====
`timescale 1ns/1ps

module apb_status_slave (
    input  monitor_pkg::apb_req_t     apb_req,
    output monitor_pkg::apb_rsp_t     apb_rsp,
    input  monitor_pkg::sensor_code_t codes [monitor_pkg::num_channels],
    input  monitor_pkg::event_count_t correction_count,
    input  monitor_pkg::event_count_t uncorrectable_count,
    input  monitor_pkg::seu_status_t  live_status,
    output logic                      count_clear
);
    import monitor_pkg::*;

    logic      access;
    apb_addr_t sensor_off;
    logic      rd_hit;
    logic      wr_hit;
    apb_data_t rd_value;

    assign access     = apb_req.psel && apb_req.penable;   // Access phase
    assign sensor_off = apb_req.paddr - reg_sensor_base;
    assign wr_hit     = (apb_req.paddr == reg_clear);      // Only writable address

    // **************************************************
    // Read decode
    // **************************************************
    always_comb begin
        rd_hit   = 1'b1;
        rd_value = '0;
        if (apb_req.paddr[1:0] != 2'b00) begin
            rd_hit = 1'b0;                                  // Misaligned
        end else if (sensor_off < apb_addr_t'(4 * num_channels)) begin
            rd_value = apb_data_t'(codes[sensor_off[4:2]]);
        end else begin
            case (apb_req.paddr)
                reg_correction:    rd_value = apb_data_t'(correction_count);
                reg_uncorrectable: rd_value = apb_data_t'(uncorrectable_count);
                reg_status:        rd_value = apb_data_t'(live_status);
                default:           rd_hit = 1'b0;           // Clear reg is write only
            endcase
        end
    end

    // **************************************************
    // Response, zero wait states
    // **************************************************
    always_comb begin
        if (apb_req.penable) begin
            assert final (apb_req.psel)
                else $error("APB penable high without psel");
        end
        apb_rsp.pready  = 1'b1;
        apb_rsp.prdata  = '0;
        apb_rsp.pslverr = 1'b0;
        if (access) begin
            if (apb_req.pwrite) begin
                apb_rsp.pslverr = !wr_hit;
            end else if (rd_hit) begin
                apb_rsp.prdata = rd_value;
            end else begin
                apb_rsp.pslverr = 1'b1;
            end
        end
    end

    // Counters zero on the edge closing the access phase
    assign count_clear = access && apb_req.pwrite && wr_hit;

endmodule

// ==== sensor_regfile.sv ====
`timescale 1ns/1ps

module sensor_regfile (
    input  logic                        clk66m,
    input  logic                        rst_66m,
    input  monitor_pkg::sensor_sample_t sample,
    output monitor_pkg::sensor_code_t   codes [monitor_pkg::num_channels]
);
    import monitor_pkg::*;

    // **************************************************
    // Latest code per channel
    // **************************************************
    always_ff @(posedge clk66m or posedge rst_66m) begin
        if (rst_66m) begin
            for (int i = 0; i < num_channels; i++) begin
                codes[i] <= '0;
            end
        end else if (sample.valid) begin
            codes[sample.chan] <= sample.code;  // Slot named by the sample tag
        end
    end

    // Tag comes from the poller's channel slot
    assert property (@(posedge clk66m) disable iff (rst_66m)
        sample.valid |-> (sample.chan < chan_idx_t'(num_channels)))
        else $error("Sample tagged with channel %0d", sample.chan);

endmodule

// ==== seu_event_counter.sv ====
`timescale 1ns/1ps

module seu_event_counter (
    input  logic                      clk66m,
    input  logic                      rst_66m,
    input  monitor_pkg::seu_status_t  seu_status,
    input  logic                      count_clear,
    output monitor_pkg::event_count_t correction_count,
    output monitor_pkg::event_count_t uncorrectable_count,
    output monitor_pkg::seu_status_t  live_status
);
    import monitor_pkg::*;

    seu_status_t status_q1;
    seu_status_t status_q2;
    logic        correction_rise;
    logic        uncorrectable_rise;

    // Two register stages on the controller status lines
    always_ff @(posedge clk66m or posedge rst_66m) begin
        if (rst_66m) begin
            status_q1 <= '0;
            status_q2 <= '0;
        end else begin
            status_q1 <= seu_status;
            status_q2 <= status_q1;
        end
    end

    assign live_status        = status_q1;
    assign correction_rise    = status_q1.correction && !status_q2.correction;
    assign uncorrectable_rise = status_q1.uncorrectable && !status_q2.uncorrectable;

    // **************************************************
    // Event counters, clear wins over an increment
    // **************************************************
    always_ff @(posedge clk66m or posedge rst_66m) begin
        if (rst_66m) begin
            correction_count    <= '0;
            uncorrectable_count <= '0;
        end else if (count_clear) begin
            correction_count    <= '0;
            uncorrectable_count <= '0;
        end else begin
            if (correction_rise) begin
                correction_count <= correction_count + 1'b1;     // Wraps
            end
            if (uncorrectable_rise) begin
                uncorrectable_count <= uncorrectable_count + 1'b1;
            end
        end
    end

    assert property (@(posedge clk66m) disable iff (rst_66m)
        count_clear |=> (correction_count == '0) && (uncorrectable_count == '0))
        else $error("Event counts not zero after clear");

endmodule

// ==== drp_poll_sequencer.sv ====
`timescale 1ns/1ps

module drp_poll_sequencer #(
    parameter int poll_interval = 65536
) (
    input  logic                        clk66m,
    input  logic                        rst_66m,
    input  monitor_pkg::drp_rsp_t       drp_rsp,
    output logic                        den,
    output monitor_pkg::drp_addr_t      daddr,
    output monitor_pkg::sensor_sample_t sample
);
    import monitor_pkg::*;

    localparam int               cnt_w    = $clog2(poll_interval);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(poll_interval - 1);
    localparam logic [cnt_w-1:0] cnt_den  = cnt_w'(den_offset);

    logic [cnt_w-1:0] interval_cnt;
    chan_idx_t        chan;
    logic             read_pending;
    logic             interval_end;
    logic             rsp_accept;
    logic             sample_valid;
    chan_idx_t        sample_chan;
    sensor_code_t     sample_code;

    // Interval has to hold the read slot plus the reply
    if (poll_interval <= den_offset + 2) begin : g_interval_check
        $error("poll_interval too short for the DRP read slot");
    end

    // **************************************************
    // Interval timer and channel slot
    // **************************************************
    assign interval_end = (interval_cnt == cnt_last);

    always_ff @(posedge clk66m or posedge rst_66m) begin
        if (rst_66m) begin
            interval_cnt <= '0;
            chan         <= '0;
        end else if (interval_end) begin
            interval_cnt <= '0;
            chan         <= (chan == chan_idx_t'(num_channels - 1)) ? '0 : chan + 1'b1;
        end else begin
            interval_cnt <= interval_cnt + 1'b1;
        end
    end

    assign den   = (interval_cnt == cnt_den);  // One-cycle read strobe
    assign daddr = chan_to_drp_addr(chan);

    // **************************************************
    // Read tracking
    // **************************************************
    assign rsp_accept = drp_rsp.drdy && read_pending;  // Stray drdy ignored

    // A reply that misses the interval is dropped at the wrap
    always_ff @(posedge clk66m or posedge rst_66m) begin
        if (rst_66m) begin
            read_pending <= 1'b0;
        end else if (den) begin
            read_pending <= 1'b1;
        end else if (rsp_accept || interval_end) begin
            read_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk66m or posedge rst_66m) begin
        if (rst_66m) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= rsp_accept;
        end
    end

    // Channel is stable for the whole interval, so it tags the reply
    always_ff @(posedge clk66m) begin
        if (rsp_accept) begin
            sample_chan <= chan;
            sample_code <= drp_rsp.rdata[15:4];
        end
    end

    assign sample = '{valid: sample_valid, chan: sample_chan, code: sample_code};

    assert property (@(posedge clk66m) disable iff (rst_66m) den |-> !read_pending)
        else $error("DRP read issued with a read still outstanding");

endmodule

// ==== monitor_pkg.sv ====
package monitor_pkg;

    // **************************************************
    // Widths and poll constants
    // **************************************************
    localparam int num_channels = 7;
    localparam int den_offset   = 16;   // Read slot inside each poll interval

    typedef logic [2:0]  chan_idx_t;
    typedef logic [6:0]  drp_addr_t;
    typedef logic [15:0] drp_data_t;
    typedef logic [11:0] sensor_code_t;  // Upper 12 bits of the DRP word
    typedef logic [15:0] event_count_t;  // Wraps at 0xFFFF
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        logic      drdy;
        drp_data_t rdata;
    } drp_rsp_t;

    typedef struct packed {
        logic         valid;
        chan_idx_t    chan;
        sensor_code_t code;
    } sensor_sample_t;

    // Field order gives the status register layout, bit 2 down to bit 0
    typedef struct packed {
        logic uncorrectable;
        logic correction;
        logic observation;
    } seu_status_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // **************************************************
    // Register map
    // **************************************************
    localparam apb_addr_t reg_sensor_base   = 8'h00;  // Channel i at base + 4*i
    localparam apb_addr_t reg_correction    = 8'h1C;
    localparam apb_addr_t reg_uncorrectable = 8'h20;
    localparam apb_addr_t reg_status        = 8'h24;
    localparam apb_addr_t reg_clear         = 8'h28;  // Write only

    // Channel slot to sensor register address
    function automatic drp_addr_t chan_to_drp_addr(chan_idx_t chan);
        drp_addr_t addr;
        case (chan)
            3'd0:    addr = 7'h00;  // Temperature
            3'd1:    addr = 7'h01;  // Vccint
            3'd2:    addr = 7'h02;  // Vccaux
            3'd3:    addr = 7'h06;  // Vccbram
            3'd4:    addr = 7'h03;  // Vp/Vn
            3'd5:    addr = 7'h04;  // Vrefp
            3'd6:    addr = 7'h05;  // Vrefn
            default: addr = 7'h00;
        endcase
        return addr;
    endfunction

endpackage
